// File: verilog/fft8_pkg.sv
package fft8_pkg;

    localparam int DATA_W   = 16;
    localparam int N_POINTS = 8;
    localparam int ADDR_W   = 3;
    localparam int TW_FRAC  = 15;              // q15 twiddles

    typedef struct packed {
        logic signed [DATA_W-1:0] re;
        logic signed [DATA_W-1:0] im;
    } cplx_t;

    // one memory write port
    typedef struct packed {
        logic              en;
        logic [ADDR_W-1:0] addr;
        cplx_t             data;
    } ram_wr_t;

    typedef enum logic [1:0] {
        PH_IDLE,
        PH_LOAD,
        PH_COMPUTE,
        PH_UNLOAD
    } phase_e;

    // W8^k = exp(-j*2*pi*k/8), +1 and -1 saturate to 0x7fff and 0x8001
    localparam cplx_t TWIDDLE [N_POINTS] = '{
        '{16'sh7FFF, 16'sh0000},               // 1
        '{16'sh5A82, 16'shA57E},               // (1 - j) / sqrt2
        '{16'sh0000, 16'sh8001},               // -j
        '{16'shA57E, 16'shA57E},               // (-1 - j) / sqrt2
        '{16'sh8001, 16'sh0000},               // -1
        '{16'shA57E, 16'sh5A82},               // (-1 + j) / sqrt2
        '{16'sh0000, 16'sh7FFF},               // j
        '{16'sh5A82, 16'sh5A82}                // (1 + j) / sqrt2
    };

endpackage

// File: verilog/sample_ram.sv
module sample_ram (
    input  logic                            clk,
    input  fft8_pkg::ram_wr_t               wr_a_i,
    input  fft8_pkg::ram_wr_t               wr_b_i,
    input  logic [fft8_pkg::ADDR_W-1:0]     rd_addr_a_i,
    input  logic [fft8_pkg::ADDR_W-1:0]     rd_addr_b_i,
    output fft8_pkg::cplx_t                 rd_a_o,
    output fft8_pkg::cplx_t                 rd_b_o
);

    fft8_pkg::cplx_t mem [fft8_pkg::N_POINTS];

    always_ff @(posedge clk) begin
        if (wr_a_i.en) begin
            mem[wr_a_i.addr] <= wr_a_i.data;    // butterfly top or loader
        end
        if (wr_b_i.en) begin
            mem[wr_b_i.addr] <= wr_b_i.data;    // butterfly bottom
        end
    end

    assign rd_a_o = mem[rd_addr_a_i];
    assign rd_b_o = mem[rd_addr_b_i];

    // both ports come from separate owners, a collision would lose a result
    a_no_write_collision : assert property (
        @(posedge clk) (wr_a_i.en && wr_b_i.en) |-> (wr_a_i.addr != wr_b_i.addr)
    );

endmodule

// File: verilog/cplx_mult.sv
module cplx_mult (
    input  logic            clk,
    input  fft8_pkg::cplx_t a_i,
    input  fft8_pkg::cplx_t w_i,
    output fft8_pkg::cplx_t p_o
);

    logic signed [2*fft8_pkg::DATA_W-1:0] prod_rr_q;
    logic signed [2*fft8_pkg::DATA_W-1:0] prod_ii_q;
    logic signed [2*fft8_pkg::DATA_W-1:0] prod_ri_q;
    logic signed [2*fft8_pkg::DATA_W-1:0] prod_ir_q;
    logic signed [2*fft8_pkg::DATA_W:0]   sum_re;
    logic signed [2*fft8_pkg::DATA_W:0]   sum_im;
    fft8_pkg::cplx_t                      p_q;

    // stage one, the four partial products
    always_ff @(posedge clk) begin
        prod_rr_q <= a_i.re * w_i.re;
        prod_ii_q <= a_i.im * w_i.im;
        prod_ri_q <= a_i.re * w_i.im;
        prod_ir_q <= a_i.im * w_i.re;
    end

    always_comb begin
        sum_re = prod_rr_q - prod_ii_q;             // one extra bit, no overflow
        sum_im = prod_ri_q + prod_ir_q;
    end

    // stage two, drop the q15 fraction and keep the low word
    always_ff @(posedge clk) begin
        p_q.re <= sum_re[fft8_pkg::TW_FRAC +: fft8_pkg::DATA_W];
        p_q.im <= sum_im[fft8_pkg::TW_FRAC +: fft8_pkg::DATA_W];
    end

    assign p_o = p_q;

endmodule

// File: verilog/frame_loader.sv
module frame_loader (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            start_i,
    input  logic [fft8_pkg::DATA_W-1:0]     data_i,
    output fft8_pkg::ram_wr_t               wr_o,
    output logic                            done_o
);

    logic                           active_q;
    logic [fft8_pkg::ADDR_W-1:0]    cnt_q;

    always_ff @(posedge clk) begin
        if (!rst) begin
            active_q <= 1'b0;
            cnt_q    <= '0;
        end else if (start_i) begin
            active_q <= 1'b1;
            cnt_q    <= '0;
        end else if (active_q) begin
            cnt_q <= cnt_q + 1'b1;                  // wraps back to zero
            if (cnt_q == fft8_pkg::ADDR_W'(fft8_pkg::N_POINTS - 1)) begin
                active_q <= 1'b0;
            end
        end
    end

    always_comb begin
        wr_o.en      = active_q;
        wr_o.addr    = {cnt_q[0], cnt_q[1], cnt_q[2]};  // bit reversed slot
        wr_o.data.re = data_i;
        wr_o.data.im = '0;                          // real input only
    end

    assign done_o = active_q && (cnt_q == fft8_pkg::ADDR_W'(fft8_pkg::N_POINTS - 1));

    // a start pulse only opens a run from idle, never in the middle of one
    a_start_when_idle : assert property (
        @(posedge clk) disable iff (!rst)
        start_i |-> !wr_o.en
    );

endmodule

// File: verilog/butterfly_engine.sv
module butterfly_engine (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            start_i,
    output logic [fft8_pkg::ADDR_W-1:0]     rd_addr_a_o,
    output logic [fft8_pkg::ADDR_W-1:0]     rd_addr_b_o,
    input  fft8_pkg::cplx_t                 rd_a_i,
    input  fft8_pkg::cplx_t                 rd_b_i,
    output fft8_pkg::cplx_t                 mul_a_o,
    output fft8_pkg::cplx_t                 mul_w_o,
    input  fft8_pkg::cplx_t                 mul_p_i,
    output fft8_pkg::ram_wr_t               wr_a_o,
    output fft8_pkg::ram_wr_t               wr_b_o,
    output logic                            done_o
);

    typedef enum logic [1:0] {
        ENG_IDLE,
        ENG_ISSUE,
        ENG_DRAIN
    } eng_state_e;

    // operand and addresses riding alongside the multiplier
    typedef struct packed {
        logic [fft8_pkg::ADDR_W-1:0] top;
        logic [fft8_pkg::ADDR_W-1:0] bot;
        fft8_pkg::cplx_t             a;
    } flight_t;

    eng_state_e                     state_q;
    logic [1:0]                     stage_q;
    logic [1:0]                     k_q;
    logic [1:0]                     drain_q;
    logic [1:0]                     vld_q;
    flight_t                        fl1_q;
    flight_t                        fl2_q;
    logic                           issue;
    logic [fft8_pkg::ADDR_W-1:0]    k_ext;
    logic [fft8_pkg::ADDR_W-1:0]    span;
    logic [fft8_pkg::ADDR_W-1:0]    grp;
    logic [fft8_pkg::ADDR_W-1:0]    j_idx;
    logic [fft8_pkg::ADDR_W-1:0]    top_addr;
    logic [fft8_pkg::ADDR_W-1:0]    bot_addr;
    logic [fft8_pkg::ADDR_W-1:0]    tw_idx;
    fft8_pkg::cplx_t                sum;
    fft8_pkg::cplx_t                diff;

    assign issue = (state_q == ENG_ISSUE);

    // in-place dit addressing, span doubles every stage
    always_comb begin
        k_ext         = {1'b0, k_q};
        span          = '0;
        span[stage_q] = 1'b1;
        grp           = k_ext >> stage_q;
        j_idx         = k_ext & (span - 1'b1);
        top_addr      = ((grp << stage_q) << 1) | j_idx;
        bot_addr      = top_addr + span;
        tw_idx        = j_idx << (2'd2 - stage_q);
    end

    assign rd_addr_a_o = top_addr;
    assign rd_addr_b_o = bot_addr;
    assign mul_a_o     = rd_b_i;                    // only the bottom leg is rotated
    assign mul_w_o     = fft8_pkg::TWIDDLE[tw_idx];

    always_ff @(posedge clk) begin
        if (!rst) begin
            state_q <= ENG_IDLE;
            stage_q <= '0;
            k_q     <= '0;
            drain_q <= '0;
            vld_q   <= '0;
        end else begin
            vld_q <= {vld_q[0], issue};
            case (state_q)
                ENG_IDLE: begin
                    if (start_i) begin
                        state_q <= ENG_ISSUE;
                        stage_q <= '0;
                        k_q     <= '0;
                    end
                end
                ENG_ISSUE: begin
                    k_q <= k_q + 2'd1;              // four butterflies per stage
                    if (k_q == 2'd3) begin
                        state_q <= ENG_DRAIN;
                        drain_q <= '0;
                    end
                end
                ENG_DRAIN: begin
                    drain_q <= drain_q + 2'd1;
                    if (drain_q == 2'd2) begin      // last write has landed
                        if (stage_q == 2'd2) begin
                            state_q <= ENG_IDLE;
                        end else begin
                            stage_q <= stage_q + 2'd1;
                            state_q <= ENG_ISSUE;
                        end
                    end
                end
                default: state_q <= ENG_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        fl1_q.top <= top_addr;
        fl1_q.bot <= bot_addr;
        fl1_q.a   <= rd_a_i;
        fl2_q     <= fl1_q;
    end

    always_comb begin
        sum.re  = fl2_q.a.re + mul_p_i.re;          // wraps, no scaling
        sum.im  = fl2_q.a.im + mul_p_i.im;
        diff.re = fl2_q.a.re - mul_p_i.re;
        diff.im = fl2_q.a.im - mul_p_i.im;
        wr_a_o.en   = vld_q[1];
        wr_a_o.addr = fl2_q.top;
        wr_a_o.data = sum;
        wr_b_o.en   = vld_q[1];
        wr_b_o.addr = fl2_q.bot;
        wr_b_o.data = diff;
    end

    assign done_o = (state_q == ENG_DRAIN) && (drain_q == 2'd2) && (stage_q == 2'd2);

    // each issued butterfly returns two cycles later to two distinct slots
    a_bfly_writeback : assert property (
        @(posedge clk) disable iff (!rst)
        issue |-> (top_addr != bot_addr) ##2 (wr_a_o.en && wr_a_o.addr != wr_b_o.addr)
    );

endmodule

// File: verilog/frame_unloader.sv
module frame_unloader (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            start_i,
    output logic [fft8_pkg::ADDR_W-1:0]     rd_addr_o,
    input  fft8_pkg::cplx_t                 rd_i,
    output logic                            req_o,
    output fft8_pkg::cplx_t                 data_o,
    output logic                            done_o
);

    logic                           active_q;
    logic                           valid_q;
    logic [fft8_pkg::ADDR_W-1:0]    addr_q;
    logic                           rd_go;
    fft8_pkg::cplx_t                data_q;

    assign rd_go = start_i || active_q;             // first read on the start cycle

    always_ff @(posedge clk) begin
        if (!rst) begin
            active_q <= 1'b0;
            valid_q  <= 1'b0;
            addr_q   <= '0;
        end else begin
            valid_q <= rd_go;
            if (rd_go) begin
                addr_q   <= addr_q + 1'b1;          // back to zero after X7
                active_q <= (addr_q != fft8_pkg::ADDR_W'(fft8_pkg::N_POINTS - 1));
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_go) begin
            data_q <= rd_i;
        end
    end

    assign rd_addr_o = addr_q;
    assign req_o     = valid_q;
    assign data_o    = data_q;
    assign done_o    = valid_q && !active_q;        // X7 on the port

endmodule

// File: verilog/fft8_top.sv
module fft8_top (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            req_i,
    input  logic [fft8_pkg::DATA_W-1:0]     data_i,
    output logic                            ans_o,
    output logic                            req_o,
    output fft8_pkg::cplx_t                 data_o
);

    fft8_pkg::phase_e               phase_q;
    logic                           ld_start;
    logic                           eng_start;
    logic                           unl_start;
    logic                           ld_done;
    logic                           eng_done;
    logic                           unl_done;
    logic                           unl_owner;
    fft8_pkg::ram_wr_t              ld_wr;
    fft8_pkg::ram_wr_t              eng_wr_a;
    fft8_pkg::ram_wr_t              eng_wr_b;
    fft8_pkg::ram_wr_t              ram_wr_a;
    fft8_pkg::ram_wr_t              ram_wr_b;
    logic [fft8_pkg::ADDR_W-1:0]    eng_rd_addr_a;
    logic [fft8_pkg::ADDR_W-1:0]    eng_rd_addr_b;
    logic [fft8_pkg::ADDR_W-1:0]    unl_rd_addr;
    logic [fft8_pkg::ADDR_W-1:0]    ram_rd_addr_a;
    fft8_pkg::cplx_t                ram_rd_a;
    fft8_pkg::cplx_t                ram_rd_b;
    fft8_pkg::cplx_t                mul_a;
    fft8_pkg::cplx_t                mul_w;
    fft8_pkg::cplx_t                mul_p;

    // start pulses coincide with the edge that enters the phase
    assign ld_start  = (phase_q == fft8_pkg::PH_IDLE) && req_i;
    assign eng_start = (phase_q == fft8_pkg::PH_LOAD) && ld_done;
    assign unl_start = (phase_q == fft8_pkg::PH_COMPUTE) && eng_done;

    always_ff @(posedge clk) begin
        if (!rst) begin
            phase_q <= fft8_pkg::PH_IDLE;
        end else begin
            case (phase_q)
                fft8_pkg::PH_IDLE:    if (ld_start) phase_q <= fft8_pkg::PH_LOAD;
                fft8_pkg::PH_LOAD:    if (ld_done) phase_q <= fft8_pkg::PH_COMPUTE;
                fft8_pkg::PH_COMPUTE: if (eng_done) phase_q <= fft8_pkg::PH_UNLOAD;
                fft8_pkg::PH_UNLOAD:  if (unl_done) phase_q <= fft8_pkg::PH_IDLE;
                default:              phase_q <= fft8_pkg::PH_IDLE;
            endcase
        end
    end

    // unloader takes the read port one cycle early to prefetch X0
    assign unl_owner = (phase_q == fft8_pkg::PH_UNLOAD) || unl_start;

    always_comb begin
        ram_wr_a = '0;
        ram_wr_b = '0;
        if (phase_q == fft8_pkg::PH_LOAD) begin
            ram_wr_a = ld_wr;
        end else if (phase_q == fft8_pkg::PH_COMPUTE) begin
            ram_wr_a = eng_wr_a;
            ram_wr_b = eng_wr_b;
        end
        ram_rd_addr_a = unl_owner ? unl_rd_addr : eng_rd_addr_a;
    end

    assign ans_o = (phase_q == fft8_pkg::PH_LOAD);

    sample_ram u_ram (
        .clk         (clk),
        .wr_a_i      (ram_wr_a),
        .wr_b_i      (ram_wr_b),
        .rd_addr_a_i (ram_rd_addr_a),
        .rd_addr_b_i (eng_rd_addr_b),
        .rd_a_o      (ram_rd_a),
        .rd_b_o      (ram_rd_b)
    );

    cplx_mult u_mult (
        .clk (clk),
        .a_i (mul_a),
        .w_i (mul_w),
        .p_o (mul_p)
    );

    frame_loader u_loader (
        .clk     (clk),
        .rst     (rst),
        .start_i (ld_start),
        .data_i  (data_i),
        .wr_o    (ld_wr),
        .done_o  (ld_done)
    );

    butterfly_engine u_engine (
        .clk         (clk),
        .rst         (rst),
        .start_i     (eng_start),
        .rd_addr_a_o (eng_rd_addr_a),
        .rd_addr_b_o (eng_rd_addr_b),
        .rd_a_i      (ram_rd_a),
        .rd_b_i      (ram_rd_b),
        .mul_a_o     (mul_a),
        .mul_w_o     (mul_w),
        .mul_p_i     (mul_p),
        .wr_a_o      (eng_wr_a),
        .wr_b_o      (eng_wr_b),
        .done_o      (eng_done)
    );

    frame_unloader u_unloader (
        .clk       (clk),
        .rst       (rst),
        .start_i   (unl_start),
        .rd_addr_o (unl_rd_addr),
        .rd_i      (ram_rd_a),
        .req_o     (req_o),
        .data_o    (data_o),
        .done_o    (unl_done)
    );

    // load and unload windows never overlap
    a_ans_req_exclusive : assert property (
        @(posedge clk) disable iff (!rst) !(ans_o && req_o)
    );

endmodule

// File: verification/tb_fft8.sv
module tb_fft8;

    logic                   clk;
    logic                   rst;
    logic                   req_i;
    logic [15:0]            data_i;
    logic                   ans_o;
    logic                   req_o;
    fft8_pkg::cplx_t        data_o;

    int smp    [0:15][0:7];
    int exp_re [0:15][0:7];
    int exp_im [0:15][0:7];
    int n_frames  = 0;
    int limit     = 1000;
    int cycles    = 0;
    int loads     = 0;
    int ans_run   = 0;
    int out_idx   = 0;
    int out_frame = 0;
    bit ans_prev  = 1'b0;
    bit req_seen  = 1'b0;

    fft8_top u_dut (
        .clk    (clk),
        .rst    (rst),
        .req_i  (req_i),
        .data_i (data_i),
        .ans_o  (ans_o),
        .req_o  (req_o),
        .data_o (data_o)
    );

    always #20 clk = ~clk;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic read_testdata();
        int    fd;
        int    rc;
        int    v [0:7];
        string line;
        string rest;
        fd = $fopen("verification/fft8_testdata.txt", "r");
        if (fd == 0) report_failure("could not open the test data file");
        while (!$feof(fd)) begin
            rc = $fgets(line, fd);
            if (rc > 2 && line.getc(0) != "#") begin
                rest = line.substr(1, line.len() - 1);
                rc = $sscanf(rest, "%d %d %d %d %d %d %d %d",
                             v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]);
                if (rc != 8) report_failure("malformed line in the test data file");
                if (line.getc(0) == "i") begin
                    for (int k = 0; k < 8; k++) smp[n_frames][k] = v[k];
                end else begin
                    for (int k = 0; k < 4; k++) begin
                        // a line holds X0..X3, b line X4..X7
                        exp_re[n_frames][k + (line.getc(0) == "b" ? 4 : 0)] = v[2*k];
                        exp_im[n_frames][k + (line.getc(0) == "b" ? 4 : 0)] = v[2*k+1];
                    end
                    if (line.getc(0) == "b") n_frames++;
                end
            end
        end
        $fclose(fd);
    endtask

    // one frame through the input handshake, samples on falling edges
    task automatic send_frame(input int f, input bit hold);
        int i;
        i = 0;
        req_i    = 1'b1;
        req_seen = 1'b1;
        while (i < 8) begin
            @(negedge clk);
            if (ans_o) begin
                data_i = 16'(smp[f][i]);
                i++;
            end
        end
        @(negedge clk);
        if (!hold) req_i = 1'b0;
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) report_failure("timeout, the DUT stopped producing frames");
    end

    always @(negedge clk) begin
        assert (!(ans_o && req_o))
            else report_failure("ans_o and req_o were high in the same cycle");
        if (!req_seen) begin
            assert (!ans_o && !req_o)
                else report_failure("a handshake output rose before any request");
        end
        if (ans_o) begin
            if (!ans_prev) begin
                assert (loads == out_frame)
                    else report_failure("a load started before the last frame was unloaded");
                loads++;
            end
            ans_run++;
        end else if (ans_prev) begin
            assert (ans_run == 8) else report_failure("ans_o window was not 8 cycles long");
            ans_run = 0;
        end
        ans_prev = ans_o;
        if (req_o) begin
            assert (out_frame < n_frames && out_idx < 8)
                else report_failure("req_o stayed high past the expected results");
            assert (data_o.re == exp_re[out_frame][out_idx]
                    && data_o.im == exp_im[out_frame][out_idx])
                else report_failure($sformatf(
                    "mismatch at %0t: frame %0d X%0d got (%0d,%0d) expected (%0d,%0d)",
                    $time, out_frame, out_idx, data_o.re, data_o.im,
                    exp_re[out_frame][out_idx], exp_im[out_frame][out_idx]));
            out_idx++;
        end else if (out_idx != 0) begin
            assert (out_idx == 8) else report_failure("req_o window was not 8 cycles long");
            out_idx = 0;
            out_frame++;
        end
    end

    initial begin
        clk    = 1'b0;
        rst    = 1'b0;
        req_i  = 1'b0;
        data_i = '0;
        void'($urandom(32'h5f12));
        read_testdata();
        if (n_frames == 0) report_failure("the test data file held no frames");
        limit = n_frames * 60 + 100;
        repeat (8) @(negedge clk);
        rst = 1'b1;
        for (int f = 0; f < n_frames; f++) begin
            if (f < 3 || f == 3) begin
                repeat ($urandom % 6) @(negedge clk);    // idle gap
            end
            send_frame(f, f >= 3);                      // later frames back to back
        end
        req_i = 1'b0;
        wait (out_frame == n_frames);
        repeat (3) @(negedge clk);
        $display("TEST PASSED");
        $finish;
    end

endmodule

// File: filelist.f
verilog/fft8_pkg.sv
verilog/sample_ram.sv
verilog/cplx_mult.sv
verilog/frame_loader.sv
verilog/butterfly_engine.sv
verilog/frame_unloader.sv
verilog/fft8_top.sv
verification/tb_fft8.sv

// File: Makefile
SRCS := $(shell cat filelist.f)

all: run

obj_dir/Vtb_fft8: filelist.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module tb_fft8 -f filelist.f

run: obj_dir/Vtb_fft8 verification/fft8_testdata.txt
	./obj_dir/Vtb_fft8 | tee sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

// File: verification/fft8_testdata.txt
# i: x0..x7 real input samples (decimal)
# a: re im for X0..X3, b: re im for X4..X7 (truncate and wrap expected values)
i 1000 0 0 0 0 0 0 0
a 1000 0 1000 0 1000 0 1000 0
b 1000 0 1000 0 1000 0 1000 0
i 100 100 100 100 100 100 100 100
a 793 0 1 -3 1 -1 1 -1
b 1 0 1 1 1 1 1 3
i 200 -200 200 -200 200 -200 200 -200
a -3 0 1 -1 1 0 1 1
b 1597 0 1 -1 1 0 1 1
i 32767 32767 32767 32767 32767 32767 32767 32767
a -12 0 1 -3 0 0 1 -1
b 0 0 1 1 0 0 1 3
i 1234 -567 890 42 -3000 2500 77 -1500
a -328 0 975 263 -2731 -3390 7492 1891
b -1274 0 7493 -1891 -2731 3390 976 -263
i -20000 15000 30000 -25000 10000 5 -7 32000
a -23544 0 -25432 18888 25543 -8006 30969 13366
b -2010 0 30970 -13366 25543 8006 -25431 -18888
